//--- include/link_test_consts.svh
//////////////////////////////////////////////////////////////////////
// Link test constants
// Widths, reset and training lengths, loopback channel depth
//////////////////////////////////////////////////////////////////////

`ifndef LINK_TEST_CONSTS_SVH
`define LINK_TEST_CONSTS_SVH

// Stream data width
`define LT_DATA_W 64

// Cycles the stretched reset is held after the request clears
`define LT_RST_CYCLES 16

// Cycles spent in link training
`define LT_TRAIN_CYCLES 32

// Loopback channel depth in cycles
`define LT_LINK_LATENCY 4

`endif

//--- hdl/link_status_pkg.sv
//////////////////////////////////////////////////////////////////////
// Link status package
// Status and error codes reported by the PHY
//////////////////////////////////////////////////////////////////////

`default_nettype none

package link_status_pkg;

   typedef enum logic [3:0] {
      LINK_RESET     = 4'b0000,
      LINK_WAIT_LANE = 4'b0001,
      LINK_TRAINING  = 4'b0010,
      LINK_READY     = 4'b0100
   } link_state_e;

   // Lane loss stays recorded until reset
   typedef enum logic [3:0] {
      ECODE_NONE      = 4'h0,
      ECODE_LANE_LOST = 4'h1
   } link_ecode_e;

endpackage

`default_nettype wire

//--- hdl/harness_pkg.sv
//////////////////////////////////////////////////////////////////////
// Harness package
// State types of the reset sequencer and the pattern checker
//////////////////////////////////////////////////////////////////////

`default_nettype none

package harness_pkg;

   typedef enum logic [1:0] {RST_HOLD, RST_COUNT, RST_DONE} rst_seq_state_e;

   typedef enum logic [1:0] {CHK_IDLE, CHK_RUN, CHK_ERROR} chk_state_e;

endpackage

`default_nettype wire

//--- hdl/reset_sequencer.sv
//////////////////////////////////////////////////////////////////////
// Reset sequencer
// Syncs the reset request and stretches it into a counted reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module reset_sequencer (
   input  logic fclk,
   input  logic arstn,
   input  logic rst_req,
   output logic sys_rstn
);
   import harness_pkg::*;

   localparam int CNT_W = $clog2(`LT_RST_CYCLES + 1);

   logic [1:0]       req_sync;
   logic             req_ok;
   logic [CNT_W-1:0] cnt;
   rst_seq_state_e   state;

   // Two-stage synchronizer on the request
   always_ff @(posedge fclk or negedge arstn) begin
      if (!arstn) begin
         req_sync <= 2'b00;
      end else begin
         req_sync <= {req_sync[0], rst_req};
      end
   end

   assign req_ok = req_sync[1];

   always_ff @(posedge fclk or negedge arstn) begin
      if (!arstn) begin
         state    <= RST_HOLD;
         cnt      <= '0;
         sys_rstn <= 1'b0;
      end else if (!req_ok) begin
         state    <= RST_HOLD;
         cnt      <= '0;
         sys_rstn <= 1'b0;
      end else begin
         case (state)
            RST_HOLD: begin
               state <= RST_COUNT;
               cnt   <= CNT_W'(1);
            end
            RST_COUNT: begin
               if (cnt == CNT_W'(`LT_RST_CYCLES - 1)) begin
                  state    <= RST_DONE;
                  sys_rstn <= 1'b1;
               end else begin
                  cnt <= cnt + CNT_W'(1);
               end
            end
            RST_DONE: sys_rstn <= 1'b1;
            default:  state <= RST_HOLD;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/pattern_generator.sv
//////////////////////////////////////////////////////////////////////
// Pattern generator
// Incrementing counter on the transmit stream
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module pattern_generator (
   input  logic                  fclk,
   input  logic                  sys_rstn,
   output logic [`LT_DATA_W-1:0] tx_tdata,
   output logic                  tx_tvalid,
   input  logic                  tx_tready
);

   logic tx_xfer;

   assign tx_xfer = tx_tvalid && tx_tready;

   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         tx_tvalid <= 1'b0;
         tx_tdata  <= '0;
      end else begin
         tx_tvalid <= 1'b1;
         // Hold the word under back-pressure
         if (tx_xfer) begin
            tx_tdata <= tx_tdata + `LT_DATA_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/loopback_phy.sv
//////////////////////////////////////////////////////////////////////
// Loopback PHY
// Link training FSM and a fixed-latency loopback channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module loopback_phy (
   input  logic                         fclk,
   input  logic                         sys_rstn,
   input  logic [1:0]                   sfp_enable,
   input  logic                         inject_error,
   input  logic [`LT_DATA_W-1:0]        tx_tdata,
   input  logic                         tx_tvalid,
   output logic                         tx_tready,
   output logic [`LT_DATA_W-1:0]        rx_tdata,
   output logic                         rx_tvalid,
   output link_status_pkg::link_state_e status,
   output link_status_pkg::link_ecode_e ecode,
   output logic [1:0]                   sfp_tx_enable
);
   import link_status_pkg::*;

   localparam int TRAIN_W = $clog2(`LT_TRAIN_CYCLES + 1);
   localparam int LAT     = `LT_LINK_LATENCY;

   logic [TRAIN_W-1:0]    train_cnt;
   logic                  lane_up;
   logic                  tx_xfer;
   logic [`LT_DATA_W-1:0] tx_word;
   logic [`LT_DATA_W-1:0] pipe_data [LAT];
   logic [LAT-1:0]        pipe_valid;

   assign lane_up   = sfp_enable[0];
   assign tx_tready = (status == LINK_READY);
   assign tx_xfer   = tx_tvalid && tx_tready;

   // Transmitter stays off until the PHY leaves reset
   assign sfp_tx_enable = (status == LINK_RESET) ? 2'b00 : sfp_enable;

   // Injected words get bit 0 flipped
   assign tx_word = {tx_tdata[`LT_DATA_W-1:1], tx_tdata[0] ^ inject_error};

   // Training FSM
   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         status    <= LINK_RESET;
         train_cnt <= '0;
      end else begin
         case (status)
            LINK_RESET: begin
               status <= LINK_WAIT_LANE;
            end
            LINK_WAIT_LANE: begin
               train_cnt <= '0;
               if (lane_up) begin
                  status <= LINK_TRAINING;
               end
            end
            LINK_TRAINING: begin
               if (!lane_up) begin
                  status <= LINK_WAIT_LANE;
               end else if (train_cnt == TRAIN_W'(`LT_TRAIN_CYCLES - 1)) begin
                  status <= LINK_READY;
               end else begin
                  train_cnt <= train_cnt + TRAIN_W'(1);
               end
            end
            LINK_READY: begin
               if (!lane_up) begin
                  status <= LINK_WAIT_LANE;
               end
            end
            default: status <= LINK_RESET;
         endcase
      end
   end

   // Sticky lane loss
   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         ecode <= ECODE_NONE;
      end else if (status == LINK_READY && !lane_up) begin
         ecode <= ECODE_LANE_LOST;
      end
   end

   // Channel valid bits, drained regardless of link state
   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         pipe_valid <= '0;
      end else begin
         pipe_valid <= {pipe_valid[LAT-2:0], tx_xfer};
      end
   end

   always_ff @(posedge fclk) begin
      pipe_data[0] <= tx_word;
      for (int i = 1; i < LAT; i++) begin
         pipe_data[i] <= pipe_data[i-1];
      end
   end

   assign rx_tdata  = pipe_data[LAT-1];
   assign rx_tvalid = pipe_valid[LAT-1];

endmodule

`default_nettype wire

//--- hdl/pattern_checker.sv
//////////////////////////////////////////////////////////////////////
// Pattern checker
// Compares received words with a reference counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module pattern_checker (
   input  logic                  fclk,
   input  logic                  sys_rstn,
   input  logic [`LT_DATA_W-1:0] rx_tdata,
   input  logic                  rx_tvalid,
   output logic                  data_error
);
   import harness_pkg::*;

   logic [`LT_DATA_W-1:0] ref_data;
   logic                  mismatch;
   chk_state_e            state;

   assign mismatch = rx_tvalid && (rx_tdata != ref_data);

   // Reference advances on every valid word
   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         ref_data <= '0;
      end else if (rx_tvalid) begin
         ref_data <= ref_data + `LT_DATA_W'(1);
      end
   end

   always_ff @(posedge fclk or negedge sys_rstn) begin
      if (!sys_rstn) begin
         state <= CHK_IDLE;
      end else begin
         case (state)
            CHK_IDLE: begin
               if (rx_tvalid) begin
                  state <= mismatch ? CHK_ERROR : CHK_RUN;
               end
            end
            CHK_RUN: begin
               if (mismatch) begin
                  state <= CHK_ERROR;
               end
            end
            // Held until reset
            CHK_ERROR: state <= CHK_ERROR;
            default:   state <= CHK_IDLE;
         endcase
      end
   end

   assign data_error = (state == CHK_ERROR);

endmodule

`default_nettype wire

//--- hdl/link_test_top.sv
//////////////////////////////////////////////////////////////////////
// Link test top
// Reset sequencer, pattern source and sink around the PHY, LED status
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module link_test_top (
   input  logic                         fclk,
   input  logic                         arstn,
   input  logic                         rst_req,
   input  logic [1:0]                   sfp_enable,
   input  logic                         inject_error,
   output logic [1:0]                   sfp_tx_enable,
   output link_status_pkg::link_state_e status,
   output link_status_pkg::link_ecode_e ecode,
   output logic [2:0]                   led
);
   import link_status_pkg::*;

   logic                  sys_rstn;
   logic [`LT_DATA_W-1:0] tx_tdata;
   logic                  tx_tvalid;
   logic                  tx_tready;
   logic [`LT_DATA_W-1:0] rx_tdata;
   logic                  rx_tvalid;
   logic                  rx_tready;
   logic                  data_error;

   // Receive side never back-pressures
   assign rx_tready = 1'b1;

   reset_sequencer u_reset_sequencer (
      .fclk    (fclk),
      .arstn   (arstn),
      .rst_req (rst_req),
      .sys_rstn(sys_rstn)
   );

   pattern_generator u_pattern_generator (
      .fclk     (fclk),
      .sys_rstn (sys_rstn),
      .tx_tdata (tx_tdata),
      .tx_tvalid(tx_tvalid),
      .tx_tready(tx_tready)
   );

   loopback_phy u_loopback_phy (
      .fclk         (fclk),
      .sys_rstn     (sys_rstn),
      .sfp_enable   (sfp_enable),
      .inject_error (inject_error),
      .tx_tdata     (tx_tdata),
      .tx_tvalid    (tx_tvalid),
      .tx_tready    (tx_tready),
      .rx_tdata     (rx_tdata),
      .rx_tvalid    (rx_tvalid),
      .status       (status),
      .ecode        (ecode),
      .sfp_tx_enable(sfp_tx_enable)
   );

   pattern_checker u_pattern_checker (
      .fclk      (fclk),
      .sys_rstn  (sys_rstn),
      .rx_tdata  (rx_tdata),
      .rx_tvalid (rx_tvalid && rx_tready),
      .data_error(data_error)
   );

   // Board LEDs
   assign led[0] = (status == LINK_READY);
   assign led[1] = (ecode == ECODE_NONE);
   assign led[2] = ~data_error;

endmodule

`default_nettype wire

//--- test/link_test_asserts.sv
//////////////////////////////////////////////////////////////////////
// Link test assertions
// Stream handshake and reset checks bound into the link test top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module link_test_asserts (
   input  logic                  fclk,
   input  logic                  sys_rstn,
   input  logic [`LT_DATA_W-1:0] tx_tdata,
   input  logic                  tx_tvalid,
   input  logic                  tx_tready,
   input  logic                  rx_tvalid
);

   int fail_count = 0;

   // Word held under back-pressure
   tx_hold_a: assert property (@(posedge fclk) disable iff (!sys_rstn)
      (tx_tvalid && !tx_tready) |=> $stable(tx_tdata))
      else begin
         $error("tx_tdata changed while tx_tvalid was high and tx_tready low");
         fail_count++;
      end

   // Accepted word comes back after the channel depth
   rx_latency_a: assert property (@(posedge fclk) disable iff (!sys_rstn)
      (tx_tvalid && tx_tready) |-> ##(`LT_LINK_LATENCY) rx_tvalid)
      else begin
         $error("rx_tvalid missing %0d cycles after a transfer", `LT_LINK_LATENCY);
         fail_count++;
      end

   valid_in_reset_a: assert property (@(posedge fclk)
      !sys_rstn |-> (!tx_tvalid && !rx_tvalid))
      else begin
         $error("stream valid high while sys_rstn is low");
         fail_count++;
      end

endmodule

bind link_test_top link_test_asserts u_link_test_asserts (
   .fclk     (fclk),
   .sys_rstn (sys_rstn),
   .tx_tdata (tx_tdata),
   .tx_tvalid(tx_tvalid),
   .tx_tready(tx_tready),
   .rx_tvalid(rx_tvalid)
);

`default_nettype wire

//--- test/link_test_tb.sv
//////////////////////////////////////////////////////////////////////
// Link test testbench
// Reset, loopback, error injection, lane loss and reset request
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "link_test_consts.svh"

module link_test_tb;
   import link_status_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;
   // Sync, stretch, one cycle each in reset and wait, then training
   localparam int READY_DELAY = `LT_RST_CYCLES + `LT_TRAIN_CYCLES + 4;
   localparam int MAX_STRETCH = 40 + 63;
   localparam int WATCHDOG_CYCLES = 3 + 2 * READY_DELAY + MAX_STRETCH
                                    + `LT_TRAIN_CYCLES + 100;

   logic        fclk;
   logic        arstn;
   logic        rst_req;
   logic [1:0]  sfp_enable;
   logic        inject_error;
   logic [1:0]  sfp_tx_enable;
   link_state_e status;
   link_ecode_e ecode;
   logic [2:0]  led;

   // Reference model state
   logic [1:0]                  sync_q;
   logic [`LT_LINK_LATENCY-1:0] err_sr;
   int                          ok_cnt;
   int                          lane_run;
   logic                        exp_err;
   link_state_e                 exp_status;
   link_ecode_e                 exp_ecode;

   integer seed = 32'hfdda_a092;
   int     err_count;
   int     tests_run;
   int     tests_failed;
   int     test_start_errs;
   int     cycles;
   int     reset_cycles;
   int     stretch;
   int     rx_words;

   link_test_top u_link_test_top (
      .fclk         (fclk),
      .arstn        (arstn),
      .rst_req      (rst_req),
      .sfp_enable   (sfp_enable),
      .inject_error (inject_error),
      .sfp_tx_enable(sfp_tx_enable),
      .status       (status),
      .ecode        (ecode),
      .led          (led)
   );

   initial begin
      fclk = 1'b0;
      forever #(CLK_PERIOD / 2) fclk = ~fclk;
   end

   // Status from edges with a synced request and edges with the lane up
   function automatic link_state_e expected_status(input int req_cycles,
                                                   input int lane_cycles);
      link_state_e st;
      if (req_cycles <= `LT_RST_CYCLES) begin
         st = LINK_RESET;
      end else if (lane_cycles == 0) begin
         st = LINK_WAIT_LANE;
      end else if (lane_cycles <= `LT_TRAIN_CYCLES) begin
         st = LINK_TRAINING;
      end else begin
         st = LINK_READY;
      end
      return st;
   endfunction

   function automatic logic [2:0] expected_led();
      return {~exp_err, exp_ecode == ECODE_NONE, exp_status == LINK_READY};
   endfunction

   // Transmitter off in reset, lanes passed through afterwards
   function automatic logic [1:0] expected_tx_enable();
      return (exp_status == LINK_RESET) ? 2'b00 : sfp_enable;
   endfunction

   // One rising edge of the model, inputs as sampled at that edge
   task automatic step_model();
      link_state_e prev;
      prev = exp_status;
      if (!arstn) begin
         sync_q = 2'b00;
         ok_cnt = 0;
      end else begin
         ok_cnt = sync_q[1] ? ok_cnt + 1 : 0;
         sync_q = {sync_q[0], rst_req};
      end
      lane_run = (prev != LINK_RESET && sfp_enable[0]) ? lane_run + 1 : 0;
      if (ok_cnt < `LT_RST_CYCLES) begin
         exp_ecode = ECODE_NONE;
         exp_err   = 1'b0;
         err_sr    = '0;
      end else begin
         if (prev == LINK_READY && !sfp_enable[0]) begin
            exp_ecode = ECODE_LANE_LOST;
         end
         if (err_sr[`LT_LINK_LATENCY-1]) begin
            exp_err = 1'b1;
         end
         err_sr = {err_sr[`LT_LINK_LATENCY-2:0], (prev == LINK_READY) && inject_error};
      end
      exp_status = expected_status(ok_cnt, lane_run);
   endtask

   task automatic report_mismatch(input string sig, input string exp_v, input string act_v);
      $display("Fail at %0t: %s expected %s, actual %s", $time, sig, exp_v, act_v);
      err_count++;
   endtask

   task automatic report_problem(input string what);
      $display("Error at %0t: %s", $time, what);
      err_count++;
   endtask

   task automatic next_cycle();
      @(posedge fclk);
      #(DRIVE_DELAY);
   endtask

   task automatic wait_for_status(input link_state_e target, input int limit,
                                  output int n);
      n = 0;
      while (status != target && n < limit) begin
         next_cycle();
         n++;
      end
   endtask

   function automatic int total_errors();
      return err_count + u_link_test_top.u_link_test_asserts.fail_count;
   endfunction

   task automatic finish_test(input int num, input string name);
      int errs;
      errs = total_errors() - test_start_errs;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("Test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "PASS" : "FAIL", errs);
      test_start_errs = total_errors();
   endtask

   // Compare the DUT with the model every cycle, away from the edge
   always begin
      @(posedge fclk);
      step_model();
      @(negedge fclk);
      assert (status == exp_status)
         else report_mismatch("status", exp_status.name(), status.name());
      assert (ecode == exp_ecode)
         else report_mismatch("ecode", exp_ecode.name(), ecode.name());
      assert (led == expected_led())
         else report_mismatch("led", $sformatf("%b", expected_led()), $sformatf("%b", led));
      assert (sfp_tx_enable == expected_tx_enable())
         else report_mismatch("sfp_tx_enable", $sformatf("%b", expected_tx_enable()),
                              $sformatf("%b", sfp_tx_enable));
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   initial begin
      arstn        = 1'b0;
      rst_req      = 1'b1;
      sfp_enable   = 2'b11;
      inject_error = 1'b0;
      sync_q       = 2'b00;
      err_sr       = '0;
      ok_cnt       = 0;
      lane_run     = 0;
      exp_err      = 1'b0;
      exp_status   = LINK_RESET;
      exp_ecode    = ECODE_NONE;
      err_count    = 0;
      tests_run    = 0;
      tests_failed = 0;
      test_start_errs = 0;
      repeat (3) @(posedge fclk);
      #(DRIVE_DELAY);
      arstn = 1'b1;

      wait_for_status(LINK_READY, 2 * READY_DELAY, cycles);
      assert (status == LINK_READY) else report_problem("link did not train after reset");
      assert (cycles == READY_DELAY)
         else report_mismatch("ready_delay", $sformatf("%0d", READY_DELAY),
                              $sformatf("%0d", cycles));
      finish_test(1, "reset release");

      stretch  = 40 + int'($unsigned($random(seed)) % 64);
      rx_words = 0;
      repeat (stretch) begin
         next_cycle();
         if (u_link_test_top.rx_tvalid) begin
            rx_words++;
         end
      end
      assert (rx_words > 0) else report_problem("no words came back on the receive stream");
      assert (led[2] && ecode == ECODE_NONE) else report_problem("clean loopback flagged an error");
      finish_test(2, "clean loopback");

      inject_error = 1'b1;
      next_cycle();
      inject_error = 1'b0;
      cycles = 1;
      while (led[2] && cycles < `LT_LINK_LATENCY + 2) begin
         next_cycle();
         cycles++;
      end
      assert (!led[2]) else report_problem("led[2] did not fall after an injected error");
      repeat (10) next_cycle();
      assert (!led[2]) else report_problem("data error cleared without a reset");
      finish_test(3, "error injection");

      sfp_enable = 2'b10;
      wait_for_status(LINK_WAIT_LANE, 4, cycles);
      assert (status == LINK_WAIT_LANE) else report_problem("link stayed up after lane loss");
      assert (ecode == ECODE_LANE_LOST)
         else report_mismatch("ecode", "ECODE_LANE_LOST", ecode.name());
      assert (!led[1]) else report_mismatch("led[1]", "0", $sformatf("%b", led[1]));
      repeat (5) next_cycle();
      sfp_enable = 2'b11;
      wait_for_status(LINK_READY, `LT_TRAIN_CYCLES + 4, cycles);
      assert (status == LINK_READY) else report_problem("link did not retrain on lane return");
      assert (ecode == ECODE_LANE_LOST) else report_problem("retraining cleared the lane loss code");
      finish_test(4, "lane loss");

      rst_req = 1'b0;
      repeat (2) next_cycle();
      rst_req = 1'b1;
      wait_for_status(LINK_RESET, 4, reset_cycles);
      assert (status == LINK_RESET) else report_problem("reset request did not reset the link");
      wait_for_status(LINK_READY, 2 * READY_DELAY, cycles);
      cycles = cycles + reset_cycles;
      assert (cycles == READY_DELAY)
         else report_mismatch("ready_delay", $sformatf("%0d", READY_DELAY),
                              $sformatf("%0d", cycles));
      assert (ecode == ECODE_NONE && led == 3'b111) else report_problem("reset left an error set");
      finish_test(5, "reset request");

      $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, err_count,
               u_link_test_top.u_link_test_asserts.fail_count);
      if (total_errors() == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hdl/link_status_pkg.sv
hdl/harness_pkg.sv
hdl/reset_sequencer.sv
hdl/pattern_generator.sv
hdl/loopback_phy.sv
hdl/pattern_checker.sv
hdl/link_test_top.sv
test/link_test_asserts.sv
test/link_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the link test harness with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   --top-module link_test_tb -Mdir obj_dir -o link_test_sim \
   -f project.f

./obj_dir/link_test_sim +verilator+error+limit+1000 | tee "$LOG"

if grep -qx "Everything OK" "$LOG"; then
   echo "Simulation passed"
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
